// ==== logic/axiPortalPkg.sv ====
package axiPortalPkg;

  // AXI3 general-purpose master port
  localparam int axiAddrWidth = 32;
  localparam int axiDataWidth = 32;
  localparam int axiIdWidth = 12;
  localparam int axiLenWidth = 4; // AXI3 burst length field

  // Portal request format
  localparam int portalAddrWidth = 18; // Low address bits kept
  localparam int portalIdWidth = 6;
  localparam int byteCountWidth = 10; // Four bytes per beat, up to 16 beats

  // Register file behind the portal
  localparam int portalWords = 64;
  localparam int portalIndexWidth = 6;

  localparam logic [1:0] respOkay = 2'd0;

endpackage

// ==== logic/twoEntryFifo.sv ====
`timescale 1ns/1ns

module twoEntryFifo #(
  parameter int dataWidth = 32
) (
  input  logic                 CLK,
  input  logic                 reset,
  input  logic                 push,
  input  logic [dataWidth-1:0] pushData,
  input  logic                 pop,
  output logic [dataWidth-1:0] popData,
  output logic                 notFull,
  output logic                 notEmpty
);

  logic [dataWidth-1:0] headData;
  logic [dataWidth-1:0] tailData;

  assign popData = headData;

  always_ff @(posedge CLK) begin
    if (reset) begin
      notEmpty <= 1'b0;
      notFull <= 1'b1;
    end else begin
      case ({push, pop})
        2'b10: begin
          notEmpty <= 1'b1;
          if (notEmpty) notFull <= 1'b0; // Second slot taken
        end
        2'b01: begin
          notFull <= 1'b1;
          if (notFull) notEmpty <= 1'b0; // Last entry leaves
        end
        default: ; // Push with pop keeps the count
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (push && (!notEmpty || (pop && notFull))) begin
      headData <= pushData; // Empty, or one entry replaced in place
    end else if (pop) begin
      headData <= tailData;
    end
    if (push && notEmpty && !pop) tailData <= pushData;
  end

  assert property (@(posedge CLK) disable iff (reset) push |-> notFull)
    else $error("push into a full buffer");
  assert property (@(posedge CLK) disable iff (reset) pop |-> notEmpty)
    else $error("pop from an empty buffer");

endmodule

// ==== logic/requestDecoder.sv ====
`timescale 1ns/1ns

module requestDecoder (
  input  logic                                    CLK,
  input  logic                                    reset,
  input  logic                                    addrValid,
  output logic                                    addrReady,
  input  logic [axiPortalPkg::axiAddrWidth-1:0]   addr,
  input  logic [axiPortalPkg::axiLenWidth-1:0]    len,
  input  logic [axiPortalPkg::axiIdWidth-1:0]     id,
  output logic                                    reqValid,
  output logic [axiPortalPkg::portalAddrWidth-1:0] reqAddr,
  output logic [axiPortalPkg::byteCountWidth-1:0] reqByteCount,
  output logic [axiPortalPkg::portalIdWidth-1:0]  reqId,
  input  logic                                    reqTake
);

  import axiPortalPkg::*;

  // Ready whenever the single slot is free
  assign addrReady = addrValid && !reqValid;

  always_ff @(posedge CLK) begin
    if (reset) begin
      reqValid <= 1'b0;
    end else if (addrReady) begin
      reqValid <= 1'b1;
    end else if (reqTake) begin
      reqValid <= 1'b0;
    end
  end

  always_ff @(posedge CLK) begin
    if (addrReady) begin
      reqAddr <= addr[portalAddrWidth-1:0];
      // Burst length field is beats minus one
      reqByteCount <= (byteCountWidth'(len) + byteCountWidth'(1)) << 2;
      reqId <= id[portalIdWidth-1:0];
    end
  end

  assert property (@(posedge CLK) disable iff (reset) reqTake |-> reqValid)
    else $error("request taken while none is held");

endmodule

// ==== logic/portalRegisterFile.sv ====
`timescale 1ns/1ns

module portalRegisterFile (
  input  logic                                     CLK,
  input  logic                                     reset,
  input  logic                                     writeReqValid,
  input  logic [axiPortalPkg::portalAddrWidth-1:0] writeReqAddr,
  input  logic [axiPortalPkg::byteCountWidth-1:0]  writeReqByteCount,
  input  logic [axiPortalPkg::portalIdWidth-1:0]   writeReqId,
  output logic                                     writeReqTake,
  input  logic                                     wBeatValid,
  input  logic [axiPortalPkg::axiDataWidth-1:0]    wBeatData,
  input  logic [axiPortalPkg::portalIdWidth-1:0]   wBeatId,
  input  logic                                     wBeatLast,
  output logic                                     wBeatPop,
  output logic                                     writeDone,
  output logic [axiPortalPkg::portalIdWidth-1:0]   writeDoneId,
  input  logic                                     bufferBEmpty,
  input  logic                                     readReqValid,
  input  logic [axiPortalPkg::portalAddrWidth-1:0] readReqAddr,
  input  logic [axiPortalPkg::byteCountWidth-1:0]  readReqByteCount,
  input  logic [axiPortalPkg::portalIdWidth-1:0]   readReqId,
  output logic                                     readReqTake,
  output logic                                     readBeat,
  output logic [axiPortalPkg::axiDataWidth-1:0]    readBeatData,
  output logic [axiPortalPkg::portalIdWidth-1:0]   readBeatId,
  output logic                                     readBeatLast,
  input  logic                                     readBeatReady
);

  import axiPortalPkg::*;

  logic [axiDataWidth-1:0] mem [portalWords];

  logic                        writeActive;
  logic [portalIndexWidth-1:0] writeIndex;
  logic [byteCountWidth-3:0]   writeBeat; // Counts from one
  logic [byteCountWidth-3:0]   writeBeats;
  logic [portalIdWidth-1:0]    writeId;
  logic                        finalWrite;

  logic                        readActive;
  logic [portalIndexWidth-1:0] readIndex;
  logic [byteCountWidth-3:0]   readCount;
  logic [byteCountWidth-3:0]   readBeats;
  logic [portalIdWidth-1:0]    readId;

  // Write sequencer
  assign writeReqTake = writeReqValid && !writeActive;
  assign finalWrite = writeBeat == writeBeats;
  // Last beat waits for room on the B side
  assign wBeatPop = writeActive && wBeatValid && (!finalWrite || bufferBEmpty);
  assign writeDone = wBeatPop && finalWrite;
  assign writeDoneId = writeId;

  always_ff @(posedge CLK) begin
    if (reset) begin
      writeActive <= 1'b0;
    end else if (writeReqTake) begin
      writeActive <= 1'b1;
    end else if (writeDone) begin
      writeActive <= 1'b0;
    end
  end

  always_ff @(posedge CLK) begin
    if (writeReqTake) begin
      writeIndex <= writeReqAddr[portalIndexWidth+1:2];
      writeBeat <= (byteCountWidth-2)'(1);
      writeBeats <= writeReqByteCount[byteCountWidth-1:2];
      writeId <= writeReqId;
    end else if (wBeatPop) begin
      writeIndex <= writeIndex + portalIndexWidth'(1); // Wraps at portalWords
      writeBeat <= writeBeat + (byteCountWidth-2)'(1);
    end
  end

  always_ff @(posedge CLK) begin
    if (wBeatPop) mem[writeIndex] <= wBeatData;
  end

  // Read sequencer
  assign readReqTake = readReqValid && !readActive;
  assign readBeat = readActive && readBeatReady;
  assign readBeatData = mem[readIndex];
  assign readBeatId = readId;
  assign readBeatLast = readCount == readBeats;

  always_ff @(posedge CLK) begin
    if (reset) begin
      readActive <= 1'b0;
    end else if (readReqTake) begin
      readActive <= 1'b1;
    end else if (readBeat && readBeatLast) begin
      readActive <= 1'b0;
    end
  end

  always_ff @(posedge CLK) begin
    if (readReqTake) begin
      readIndex <= readReqAddr[portalIndexWidth+1:2];
      readCount <= (byteCountWidth-2)'(1);
      readBeats <= readReqByteCount[byteCountWidth-1:2];
      readId <= readReqId;
    end else if (readBeat) begin
      readIndex <= readIndex + portalIndexWidth'(1);
      readCount <= readCount + (byteCountWidth-2)'(1);
    end
  end

  // W stream must line up with the AW burst that owns it
  assert property (@(posedge CLK) disable iff (reset)
    wBeatPop |-> (wBeatId == writeId) && (wBeatLast == finalWrite))
    else $error("W beat id or last does not match the active write");

endmodule

// ==== logic/axiResponder.sv ====
`timescale 1ns/1ns

module axiResponder (
  input  logic                                   CLK,
  input  logic                                   reset,
  input  logic                                   writeDone,
  input  logic [axiPortalPkg::portalIdWidth-1:0] writeDoneId,
  output logic                                   bufferBEmpty,
  input  logic                                   readBeat,
  input  logic [axiPortalPkg::axiDataWidth-1:0]  readBeatData,
  input  logic [axiPortalPkg::portalIdWidth-1:0] readBeatId,
  input  logic                                   readBeatLast,
  output logic                                   readBeatReady,
  input  logic                                   bReady,
  input  logic                                   rReady,
  output logic                                   bValid,
  output logic [axiPortalPkg::axiIdWidth-1:0]    bId,
  output logic [1:0]                             bResp,
  output logic                                   rValid,
  output logic [axiPortalPkg::axiDataWidth-1:0]  rData,
  output logic [axiPortalPkg::axiIdWidth-1:0]    rId,
  output logic [1:0]                             rResp,
  output logic                                   rLast
);

  import axiPortalPkg::*;

  logic [portalIdWidth-1:0]             bDoneId;
  logic [axiDataWidth+axiIdWidth+2:0]   rPushData; // Data, resp, last, id
  logic [axiDataWidth+axiIdWidth+2:0]   rPopData;

  twoEntryFifo #(.dataWidth(portalIdWidth)) bBuffer (
    .CLK(CLK), .reset(reset),
    .push(writeDone), .pushData(writeDoneId),
    .pop(bValid && bReady), .popData(bDoneId),
    .notFull(), .notEmpty(bValid)
  );

  assign bufferBEmpty = !bValid;
  assign bId = {{(axiIdWidth-portalIdWidth){1'b0}}, bDoneId};
  assign bResp = respOkay;

  // R beat is stored already in AXI order
  assign rPushData = {readBeatData, respOkay, readBeatLast,
                      {(axiIdWidth-portalIdWidth){1'b0}}, readBeatId};

  twoEntryFifo #(.dataWidth(axiDataWidth+axiIdWidth+3)) rBuffer (
    .CLK(CLK), .reset(reset),
    .push(readBeat), .pushData(rPushData),
    .pop(rValid && rReady), .popData(rPopData),
    .notFull(), .notEmpty(rValid)
  );

  assign readBeatReady = !rValid; // One R beat in flight
  assign rData = rPopData[axiDataWidth+axiIdWidth+2:axiIdWidth+3];
  assign rResp = rPopData[axiIdWidth+2:axiIdWidth+1];
  assign rLast = rPopData[axiIdWidth];
  assign rId = rPopData[axiIdWidth-1:0];

endmodule

// ==== logic/axiPortalBridge.sv ====
`timescale 1ns/1ns

module axiPortalBridge (
  input  logic                                  CLK,
  input  logic                                  reset,
  input  logic [axiPortalPkg::axiAddrWidth-1:0] awAddr,
  input  logic [axiPortalPkg::axiLenWidth-1:0]  awLen,
  input  logic [axiPortalPkg::axiIdWidth-1:0]   awId,
  input  logic                                  awValid,
  output logic                                  awReady,
  input  logic [axiPortalPkg::axiDataWidth-1:0] wData,
  input  logic [axiPortalPkg::axiIdWidth-1:0]   wId,
  input  logic                                  wLast,
  input  logic                                  wValid,
  output logic                                  wReady,
  output logic [axiPortalPkg::axiIdWidth-1:0]   bId,
  output logic [1:0]                            bResp,
  output logic                                  bValid,
  input  logic                                  bReady,
  input  logic [axiPortalPkg::axiAddrWidth-1:0] arAddr,
  input  logic [axiPortalPkg::axiLenWidth-1:0]  arLen,
  input  logic [axiPortalPkg::axiIdWidth-1:0]   arId,
  input  logic                                  arValid,
  output logic                                  arReady,
  output logic [axiPortalPkg::axiDataWidth-1:0] rData,
  output logic [axiPortalPkg::axiIdWidth-1:0]   rId,
  output logic [1:0]                            rResp,
  output logic                                  rLast,
  output logic                                  rValid,
  input  logic                                  rReady
);

  import axiPortalPkg::*;

  logic                       writeReqValid, writeReqTake;
  logic [portalAddrWidth-1:0] writeReqAddr;
  logic [byteCountWidth-1:0]  writeReqByteCount;
  logic [portalIdWidth-1:0]   writeReqId;

  logic                       readReqValid, readReqTake;
  logic [portalAddrWidth-1:0] readReqAddr;
  logic [byteCountWidth-1:0]  readReqByteCount;
  logic [portalIdWidth-1:0]   readReqId;

  logic                       wNotFull, wBeatValid, wBeatPop, wBeatLast;
  logic [axiDataWidth-1:0]    wBeatData;
  logic [portalIdWidth-1:0]   wBeatId;

  logic                       writeDone, bufferBEmpty;
  logic [portalIdWidth-1:0]   writeDoneId;
  logic                       readBeat, readBeatReady, readBeatLast;
  logic [axiDataWidth-1:0]    readBeatData;
  logic [portalIdWidth-1:0]   readBeatId;

  requestDecoder awDecoder (
    .CLK(CLK), .reset(reset),
    .addrValid(awValid), .addrReady(awReady),
    .addr(awAddr), .len(awLen), .id(awId),
    .reqValid(writeReqValid), .reqAddr(writeReqAddr),
    .reqByteCount(writeReqByteCount), .reqId(writeReqId),
    .reqTake(writeReqTake)
  );

  requestDecoder arDecoder (
    .CLK(CLK), .reset(reset),
    .addrValid(arValid), .addrReady(arReady),
    .addr(arAddr), .len(arLen), .id(arId),
    .reqValid(readReqValid), .reqAddr(readReqAddr),
    .reqByteCount(readReqByteCount), .reqId(readReqId),
    .reqTake(readReqTake)
  );

  assign wReady = wValid && wNotFull;

  twoEntryFifo #(.dataWidth(axiDataWidth+portalIdWidth+1)) wBuffer (
    .CLK(CLK), .reset(reset),
    .push(wReady), .pushData({wData, wId[portalIdWidth-1:0], wLast}),
    .pop(wBeatPop), .popData({wBeatData, wBeatId, wBeatLast}),
    .notFull(wNotFull), .notEmpty(wBeatValid)
  );

  portalRegisterFile portalRegisterFile_i (
    .CLK(CLK), .reset(reset),
    .writeReqValid(writeReqValid), .writeReqAddr(writeReqAddr),
    .writeReqByteCount(writeReqByteCount), .writeReqId(writeReqId),
    .writeReqTake(writeReqTake),
    .wBeatValid(wBeatValid), .wBeatData(wBeatData),
    .wBeatId(wBeatId), .wBeatLast(wBeatLast), .wBeatPop(wBeatPop),
    .writeDone(writeDone), .writeDoneId(writeDoneId), .bufferBEmpty(bufferBEmpty),
    .readReqValid(readReqValid), .readReqAddr(readReqAddr),
    .readReqByteCount(readReqByteCount), .readReqId(readReqId),
    .readReqTake(readReqTake),
    .readBeat(readBeat), .readBeatData(readBeatData),
    .readBeatId(readBeatId), .readBeatLast(readBeatLast),
    .readBeatReady(readBeatReady)
  );

  axiResponder axiResponder_i (
    .CLK(CLK), .reset(reset),
    .writeDone(writeDone), .writeDoneId(writeDoneId), .bufferBEmpty(bufferBEmpty),
    .readBeat(readBeat), .readBeatData(readBeatData),
    .readBeatId(readBeatId), .readBeatLast(readBeatLast),
    .readBeatReady(readBeatReady),
    .bReady(bReady), .rReady(rReady),
    .bValid(bValid), .bId(bId), .bResp(bResp),
    .rValid(rValid), .rData(rData), .rId(rId), .rResp(rResp), .rLast(rLast)
  );

endmodule

// ==== verification/axiPortalBridgeTb.sv ====
`timescale 1ns/1ns

module axiPortalBridgeTb;

  import axiPortalPkg::*;

  typedef struct packed {
    logic                    isWrite;
    logic [axiAddrWidth-1:0] addr;
    logic [axiLenWidth-1:0]  len;
    logic [axiIdWidth-1:0]   id;
    logic [axiIdWidth-1:0]   expId; // Low 6 bits zero-extended
  } testEntry;

  logic                    CLK;
  logic                    reset;
  logic [axiAddrWidth-1:0] awAddr;
  logic [axiLenWidth-1:0]  awLen;
  logic [axiIdWidth-1:0]   awId;
  logic                    awValid;
  logic                    awReady;
  logic [axiDataWidth-1:0] wData;
  logic [axiIdWidth-1:0]   wId;
  logic                    wLast;
  logic                    wValid;
  logic                    wReady;
  logic [axiIdWidth-1:0]   bId;
  logic [1:0]              bResp;
  logic                    bValid;
  logic                    bReady;
  logic [axiAddrWidth-1:0] arAddr;
  logic [axiLenWidth-1:0]  arLen;
  logic [axiIdWidth-1:0]   arId;
  logic                    arValid;
  logic                    arReady;
  logic [axiDataWidth-1:0] rData;
  logic [axiIdWidth-1:0]   rId;
  logic [1:0]              rResp;
  logic                    rLast;
  logic                    rValid;
  logic                    rReady;

  testEntry tests [$];
  logic [axiDataWidth-1:0] refMem [portalWords]; // Expected portal contents
  int timeoutCycles = 0;

  axiPortalBridge axiPortalBridge_i (
    .CLK(CLK), .reset(reset),
    .awAddr(awAddr), .awLen(awLen), .awId(awId), .awValid(awValid), .awReady(awReady),
    .wData(wData), .wId(wId), .wLast(wLast), .wValid(wValid), .wReady(wReady),
    .bId(bId), .bResp(bResp), .bValid(bValid), .bReady(bReady),
    .arAddr(arAddr), .arLen(arLen), .arId(arId), .arValid(arValid), .arReady(arReady),
    .rData(rData), .rId(rId), .rResp(rResp), .rLast(rLast), .rValid(rValid),
    .rReady(rReady)
  );

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    if (actual !== expected) begin
      $display("CHECK FAILED at %0t ns: %s expected 0x%h, got 0x%h",
               $time, name, expected, actual);
      $display("Simulation finished: FAIL");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic addTest(input logic isWrite, input logic [31:0] addr, input logic [3:0] len,
                         input logic [11:0] id, input logic [11:0] expId);
    tests.push_back('{isWrite, addr, len, id, expId});
  endtask

  function automatic int countBeats();
    int total;
    total = 0;
    foreach (tests[i]) total += int'(tests[i].len) + 1;
    return total;
  endfunction

  task automatic runWrite(input testEntry t);
    logic [portalIndexWidth-1:0] index;
    logic [axiDataWidth-1:0]     data;
    int                          stall;
    index = t.addr[7:2];
    awAddr <= t.addr;
    awLen <= t.len;
    awId <= t.id;
    awValid <= 1'b1;
    do @(posedge CLK); while (!awReady);
    awValid <= 1'b0;
    for (int beat = 0; beat <= int'(t.len); beat++) begin
      data = $urandom;
      refMem[index] = data; // Wraps at portalWords
      index = index + 6'd1;
      wData <= data;
      wId <= t.id;
      wLast <= (beat == int'(t.len));
      wValid <= 1'b1;
      do @(posedge CLK); while (!wReady);
    end
    wValid <= 1'b0;
    wLast <= 1'b0;
    stall = int'($urandom % 6);
    repeat (stall) @(posedge CLK);
    bReady <= 1'b1;
    do @(posedge CLK); while (!bValid);
    checkValue("bId", 32'(t.expId), 32'(bId));
    checkValue("bResp", 32'(respOkay), 32'(bResp));
    bReady <= 1'b0;
    @(posedge CLK);
    checkValue("bValid", 32'(0), 32'(bValid)); // Only one B per burst
  endtask

  task automatic runRead(input testEntry t);
    logic [portalIndexWidth-1:0] index;
    int                          stall;
    index = t.addr[7:2];
    arAddr <= t.addr;
    arLen <= t.len;
    arId <= t.id;
    arValid <= 1'b1;
    do @(posedge CLK); while (!arReady);
    arValid <= 1'b0;
    for (int beat = 0; beat <= int'(t.len); beat++) begin
      stall = int'($urandom % 4);
      rReady <= 1'b0;
      repeat (stall) @(posedge CLK);
      rReady <= 1'b1;
      do @(posedge CLK); while (!rValid);
      checkValue("rData", refMem[index], rData);
      checkValue("rId", 32'(t.expId), 32'(rId));
      checkValue("rResp", 32'(respOkay), 32'(rResp));
      checkValue("rLast", 32'(beat == int'(t.len)), 32'(rLast));
      index = index + 6'd1;
    end
    rReady <= 1'b0;
    @(posedge CLK);
    checkValue("rValid", 32'(0), 32'(rValid));
  endtask

  // Ends the run if the bridge stops making progress
  initial begin
    wait (timeoutCycles > 0);
    repeat (timeoutCycles) @(posedge CLK);
    $display("Timeout: the transactions did not finish within %0d cycles", timeoutCycles);
    $display("Simulation finished: FAIL");
    $fatal(1, "watchdog expired");
  end

  initial begin
    void'($urandom(78));
    reset = 1'b1;
    awAddr = '0;
    awLen = '0;
    awId = '0;
    awValid = 1'b0;
    wData = '0;
    wId = '0;
    wLast = 1'b0;
    wValid = 1'b0;
    bReady = 1'b0;
    arAddr = '0;
    arLen = '0;
    arId = '0;
    arValid = 1'b0;
    rReady = 1'b0;

    addTest(1'b1, 32'h0000_0010, 4'd0, 12'h005, 12'h005); // Single beat
    addTest(1'b0, 32'h0000_0010, 4'd0, 12'h006, 12'h006);
    addTest(1'b1, 32'h0000_0040, 4'd3, 12'h011, 12'h011); // Four-beat burst
    addTest(1'b0, 32'h0000_0040, 4'd3, 12'h012, 12'h012);
    addTest(1'b1, 32'h0000_0024, 4'd0, 12'hAC3, 12'h003); // High id bits dropped
    addTest(1'b0, 32'h0000_0024, 4'd0, 12'hF7E, 12'h03E);
    addTest(1'b1, 32'h0000_0110, 4'd0, 12'h021, 12'h021); // Aliases 0x10
    addTest(1'b0, 32'h0000_0010, 4'd0, 12'h022, 12'h022);
    addTest(1'b1, 32'h0000_03F8, 4'd3, 12'h101, 12'h001); // Index wraps past 63
    addTest(1'b0, 32'h0000_00F8, 4'd3, 12'h0C2, 12'h002);
    addTest(1'b1, 32'h0000_0080, 4'd1, 12'h033, 12'h033);
    addTest(1'b0, 32'h0000_0080, 4'd1, 12'h034, 12'h034);
    timeoutCycles = 200 + 40 * countBeats();

    repeat (5) @(posedge CLK);
    reset <= 1'b0;
    @(posedge CLK);
    checkValue("bValid", 32'(0), 32'(bValid));
    checkValue("rValid", 32'(0), 32'(rValid));
    // Readies follow their valids, all low here
    checkValue("awReady", 32'(0), 32'(awReady));
    checkValue("wReady", 32'(0), 32'(wReady));
    checkValue("arReady", 32'(0), 32'(arReady));

    foreach (tests[i]) begin
      if (tests[i].isWrite) runWrite(tests[i]);
      else runRead(tests[i]);
    end

    repeat (2) @(posedge CLK);
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

// ==== src.f ====
logic/axiPortalPkg.sv
logic/twoEntryFifo.sv
logic/requestDecoder.sv
logic/portalRegisterFile.sv
logic/axiResponder.sv
logic/axiPortalBridge.sv
verification/axiPortalBridgeTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

log=sim.log
rm -rf obj_dir "$log"

verilator --binary --timing --assert --timescale 1ns/1ns \
  --top-module axiPortalBridgeTb -f src.f -o simv \
  && ./obj_dir/simv > "$log" 2>&1 \
  || echo "build or simulation returned an error" >> "$log"

cat "$log"

grep -q "Simulation finished: FAIL" "$log" && exit 1
grep -q "Simulation finished: PASS" "$log" || exit 1
exit 0
